// ==== sd_dma.f ====
source/sd_dma_pkg.sv
source/mem_bus_if.sv
source/system_ram.sv
source/adma_engine.sv
source/data_fifo.sv
source/sd_dma_top.sv
testbench/dma_checker.sv
testbench/tb_sd_dma.sv

// ==== run_sim.sh ====
#!/bin/bash
# build the DMA testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_sd_dma \
   -f sd_dma.f -o tb_sd_dma

./obj_dir/tb_sd_dma | tee sim.log

# fails the script when the pass line is absent
grep -q "TESTBENCH PASSED" sim.log

// ==== testbench/tb_sd_dma.sv ====
/*
 * case table of descriptor chains, applied one row at a time
 * memory is preloaded once, descriptors of each row are written before start
 * card_ready is random with long stretches low
 */
module tb_sd_dma;
   import sd_dma_pkg::*;

   typedef struct packed {
      logic [addr_w-1:0] place;    // byte address of word 0
      logic [5:0]        attr;
      logic [15:0]       len;      // words
      logic [addr_w-1:0] addr;     // word 1
   } desc_t;

   typedef struct packed {
      logic [3:0]        first;    // first entry in desc_tab
      logic [2:0]        n;        // entries in this case
      logic [addr_w-1:0] base;
      logic              exp_err;
      logic [7:0]        exp_count;
      logic              poke;     // host write during busy
   } case_t;

   localparam int n_desc  = 9;
   localparam int n_cases = 5;

   desc_t desc_tab [n_desc] = '{
      '{10'h300, 6'h13, 16'd6,  10'h040},   // single transfer, end
      '{10'h310, 6'h11, 16'd4,  10'h100},   // chain, first block
      '{10'h318, 6'h01, 16'd0,  10'h000},   // nop
      '{10'h320, 6'h31, 16'd0,  10'h340},   // link
      '{10'h340, 6'h13, 16'd20, 10'h200},   // last block, end
      '{10'h360, 6'h12, 16'd3,  10'h000},   // valid bit clear
      '{10'h368, 6'h13, 16'd3,  10'h042},   // unaligned data
      '{10'h370, 6'h31, 16'd0,  10'h378},   // link loop
      '{10'h378, 6'h31, 16'd0,  10'h370}
   };

   case_t case_tab [n_cases] = '{
      '{4'd0, 3'd1, 10'h300, 1'b0, 8'd6,  1'b1},
      '{4'd1, 3'd4, 10'h310, 1'b0, 8'd24, 1'b0},   // reads the poked word
      '{4'd5, 3'd1, 10'h360, 1'b1, 8'd0,  1'b0},
      '{4'd6, 3'd1, 10'h368, 1'b1, 8'd0,  1'b0},
      '{4'd7, 3'd2, 10'h370, 1'b1, 8'd0,  1'b0}
   };

   logic              CLK;
   logic              reset;
   logic              start;
   logic [addr_w-1:0] desc_base;
   logic [addr_w-1:0] host_addr;
   logic [data_w-1:0] host_wdata;
   logic              host_we;
   logic [data_w-1:0] card_data;
   logic              card_valid;
   logic              card_ready;
   logic              busy;
   logic              done;
   logic              err;
   logic              check;
   logic              exp_err;
   logic [7:0]        exp_count;
   int                chk_errors;
   int                timeouts = 0;
   int                seed = 32'h90b6;

   sd_dma_top dut0 (
      .CLK(CLK), .reset(reset), .start(start), .desc_base(desc_base),
      .host_addr(host_addr), .host_wdata(host_wdata), .host_we(host_we),
      .card_data(card_data), .card_valid(card_valid), .card_ready(card_ready),
      .busy(busy), .done(done), .err(err)
   );

   dma_checker chk0 (
      .CLK(CLK), .reset(reset), .start(start), .desc_base(desc_base),
      .host_addr(host_addr), .host_wdata(host_wdata), .host_we(host_we),
      .card_data(card_data), .card_valid(card_valid), .card_ready(card_ready),
      .busy(busy), .done(done), .err(err), .check(check),
      .exp_err(exp_err), .exp_count(exp_count), .errors(chk_errors)
   );

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   // card side ready, random level held for 1 to 16 cycles
   initial begin
      int r;
      int run_left;
      run_left   = 0;
      card_ready = 1'b0;
      forever begin
         @(posedge CLK);
         #2;
         if (run_left == 0) begin
            r          = $random(seed);
            card_ready = r[0];
            run_left   = 1 + int'(r[4:1]);
         end
         run_left--;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////
   task automatic next_slot();
      @(posedge CLK);
      #2;                      // inputs move just after the edge
   endtask

   task automatic host_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
      host_addr  = a;
      host_wdata = d;
      host_we    = 1'b1;
      next_slot();
      host_we    = 1'b0;
   endtask

   task automatic wait_end(input int idx);
      int i;
      for (i = 0; i < 3000 && !(done || err); i++) @(negedge CLK);
      if (!(done || err)) begin
         timeouts++;
         $display("timeout, case %0d never reached done or err", idx);
      end
   endtask

   task automatic wait_drain(input int idx);
      int i;
      for (i = 0; i < 3000 && card_valid; i++) @(negedge CLK);
      if (card_valid) begin
         timeouts++;
         $display("timeout, case %0d card stream never drained", idx);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      case_t row;
      desc_t d;
      int    i;
      int    k;
      reset      = 1'b1;
      start      = 1'b0;
      desc_base  = '0;
      host_addr  = '0;
      host_wdata = '0;
      host_we    = 1'b0;
      check      = 1'b0;
      exp_err    = 1'b0;
      exp_count  = '0;
      repeat (8) @(posedge CLK);
      #2;
      reset = 1'b0;

      // data pattern over the whole byte address
      for (i = 0; i < ram_words; i++) begin
         host_write(addr_w'(i * word_bytes), 32'(i * word_bytes) * 32'd52427 + 32'hcccccccc);
      end

      for (i = 0; i < n_cases; i++) begin
         row = case_tab[i];
         for (k = 0; k < int'(row.n); k++) begin
            d = desc_tab[int'(row.first) + k];
            host_write(d.place, {d.len, 10'd0, d.attr});
            host_write(d.place + addr_w'(word_bytes), {{(data_w-addr_w){1'b0}}, d.addr});
         end
         exp_err   = row.exp_err;
         exp_count = row.exp_count;
         desc_base = row.base;
         start     = 1'b1;
         next_slot();
         start     = 1'b0;
         if (row.poke) begin
            host_write(10'h100, 32'h5a5a0f0f);   // engine busy, must be dropped
         end
         wait_end(i);
         wait_drain(i);
         next_slot();
         check = 1'b1;
         next_slot();
         check = 1'b0;
         next_slot();
      end

      $display("errors: checker %0d, timeouts %0d", chk_errors, timeouts);
      if (chk_errors == 0 && timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== testbench/dma_checker.sv ====
/*
 * watches sd_dma_top, keeps a shadow memory built from accepted host writes
 * walks the shadow descriptors on start to build the expected card stream
 */
module dma_checker (
   input  logic                          CLK,
   input  logic                          reset,
   input  logic                          start,
   input  logic [sd_dma_pkg::addr_w-1:0] desc_base,
   input  logic [sd_dma_pkg::addr_w-1:0] host_addr,
   input  logic [sd_dma_pkg::data_w-1:0] host_wdata,
   input  logic                          host_we,
   input  logic [sd_dma_pkg::data_w-1:0] card_data,
   input  logic                          card_valid,
   input  logic                          card_ready,
   input  logic                          busy,
   input  logic                          done,
   input  logic                          err,
   input  logic                          check,       // case over and stream drained
   input  logic                          exp_err,     // from the case table
   input  logic [7:0]                    exp_count,
   output int                            errors
);
   import sd_dma_pkg::*;

   logic [data_w-1:0] shadow [ram_words];   // memory as the host left it
   logic [data_w-1:0] exp_q [$];            // words still owed on the card side
   logic [data_w-1:0] w;
   bit                rst_q;                // seen one reset edge already
   bit                in_run;
   bit                model_err;
   bit                seen_done;
   bit                seen_err;
   int                got_count;

   ////////////////////////////////////////////////////////////////////////////
   // reference walk of the descriptor table
   ////////////////////////////////////////////////////////////////////////////
   task automatic walk_table(input logic [addr_w-1:0] base);
      logic [addr_w-1:0] a;
      logic [addr_w-1:0] a1;
      logic [addr_w-1:0] tgt;
      logic [data_w-1:0] w0;
      logic [addr_w-3:0] wi;
      adma_act_t         act;
      int                steps;
      int                i;
      bit                fin;
      a         = base;
      steps     = 0;
      model_err = (base[1:0] != 2'b00);   // unaligned base fails at once
      fin       = model_err;
      exp_q.delete();
      while (!fin) begin
         a1  = a + addr_w'(word_bytes);
         w0  = shadow[a[addr_w-1:2]];
         tgt = shadow[a1[addr_w-1:2]][addr_w-1:0];
         act = adma_act_t'(w0[act_msb:act_lsb]);
         if (!w0[attr_valid] || steps == max_steps) begin
            model_err = 1'b1;
         end else if ((act == act_tran || act == act_link) && tgt[1:0] != 2'b00) begin
            model_err = 1'b1;                // target must be a whole word
         end else begin
            steps++;
            if (act == act_tran) begin
               wi = tgt[addr_w-1:2];
               for (i = 0; i < int'(w0[len_msb:len_lsb]); i++) begin
                  exp_q.push_back(shadow[wi]);
                  wi = wi + 1'b1;            // wraps like the byte address
               end
               a = a + addr_w'(desc_bytes);
            end else if (act == act_link) begin
               a = tgt;
            end else begin
               a = a + addr_w'(desc_bytes);  // nop, reserved
            end
         end
         fin = model_err || w0[attr_end];
      end
   endtask

   // single-bit compare against an expected level
   task automatic expect_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         errors++;
         $display("ERR t=%0t %s exp=%b got=%b", $time, name, exp, got);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // per-cycle monitor sampled on the rising edge
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge CLK) begin
      if (reset) begin
         if (rst_q) begin
            expect_bit("busy", 1'b0, busy);
            expect_bit("done", 1'b0, done);
            expect_bit("err", 1'b0, err);
            expect_bit("card_valid", 1'b0, card_valid);
         end
         rst_q  = 1'b1;
         in_run = 1'b0;
      end else begin
         // host writes land only when aligned and idle
         if (host_we && !busy && host_addr[1:0] == 2'b00) begin
            shadow[host_addr[addr_w-1:2]] = host_wdata;
         end
         if (card_valid && card_ready) begin
            got_count++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("extra word %h on the card stream at t=%0t", card_data, $time);
            end else begin
               w = exp_q.pop_front();
               if (w !== card_data) begin
                  errors++;
                  $display("ERR t=%0t card_data exp=%h got=%h", $time, w, card_data);
               end
            end
         end
         if (done) seen_done = 1'b1;
         if (err) seen_err = 1'b1;
         if (in_run) begin
            if (done || err) begin
               in_run = 1'b0;
               expect_bit("busy", 1'b0, busy);   // falls with the end pulse
            end else begin
               expect_bit("busy", 1'b1, busy);
            end
         end else if (start) begin
            in_run    = 1'b1;
            seen_done = 1'b0;
            seen_err  = 1'b0;
            got_count = 0;
            walk_table(desc_base);
         end
         if (check) begin
            if (model_err != exp_err) begin
               errors++;
               $display("case table and descriptor walk disagree on the outcome");
            end
            if (exp_err && !seen_err) begin
               errors++;
               $display("missing err at the end of a failing case");
            end
            if (!exp_err && seen_err) begin
               errors++;
               $display("unexpected err in a case that should finish");
            end
            if (exp_err && seen_done) begin
               errors++;
               $display("unexpected done in a failing case");
            end
            if (!exp_err && !seen_done) begin
               errors++;
               $display("missing done");
            end
            if (got_count != int'(exp_count)) begin
               errors++;
               $display("ERR t=%0t word_count exp=%0d got=%0d", $time, exp_count, got_count);
            end
            if (exp_q.size() != 0) begin
               errors++;
               $display("%0d words never reached the card stream", exp_q.size());
            end
         end
      end
   end

endmodule

// ==== source/sd_dma_top.sv ====
/*
 * DMA side of the SD host, memory + descriptor engine + card FIFO
 * host port is ignored while busy
 */
module sd_dma_top (
   input  logic                          CLK,
   input  logic                          reset,
   input  logic                          start,
   input  logic [sd_dma_pkg::addr_w-1:0] desc_base,
   input  logic [sd_dma_pkg::addr_w-1:0] host_addr,
   input  logic [sd_dma_pkg::data_w-1:0] host_wdata,
   input  logic                          host_we,
   output logic [sd_dma_pkg::data_w-1:0] card_data,
   output logic                          card_valid,
   input  logic                          card_ready,
   output logic                          busy,
   output logic                          done,
   output logic                          err
);
   import sd_dma_pkg::*;

   mem_bus_if mbus ();   // engine read port

   // engine to FIFO
   logic [data_w-1:0] push_data;
   logic              push_valid;
   logic              push_ready;
   logic [room_w-1:0] fifo_room;

   system_ram ram0 (
      .CLK        (CLK),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_we    (host_we),
      .busy       (busy),
      .bus        (mbus.memory)
   );

   adma_engine eng0 (
      .CLK        (CLK),
      .reset      (reset),
      .start      (start),
      .desc_base  (desc_base),
      .bus        (mbus.controller),
      .push_data  (push_data),
      .push_valid (push_valid),
      .push_ready (push_ready),
      .fifo_room  (fifo_room),
      .busy       (busy),
      .done       (done),
      .err        (err)
   );

   data_fifo fifo0 (
      .CLK        (CLK),
      .reset      (reset),
      .push_data  (push_data),
      .push_valid (push_valid),
      .push_ready (push_ready),
      .room       (fifo_room),
      .pop_data   (card_data),
      .pop_valid  (card_valid),
      .pop_ready  (card_ready)
   );

endmodule

// ==== source/data_fifo.sv ====
/*
 * synchronous FIFO toward the card stream, output straight from registers
 * room reports free entries for the engine's read pacing
 */
module data_fifo (
   input  logic                          CLK,
   input  logic                          reset,
   input  logic [sd_dma_pkg::data_w-1:0] push_data,
   input  logic                          push_valid,
   output logic                          push_ready,
   output logic [sd_dma_pkg::room_w-1:0] room,
   output logic [sd_dma_pkg::data_w-1:0] pop_data,
   output logic                          pop_valid,
   input  logic                          pop_ready
);
   import sd_dma_pkg::*;

   logic [data_w-1:0]     buf_q [fifo_depth];
   logic [fifo_ptr_w-1:0] wr_ptr;    // wraps, depth is a power of two
   logic [fifo_ptr_w-1:0] rd_ptr;
   logic [room_w-1:0]     count;
   logic                  do_push;
   logic                  do_pop;

   assign push_ready = (count != room_w'(fifo_depth));
   assign pop_valid  = (count != '0);
   assign pop_data   = buf_q[rd_ptr];   // stable until popped
   assign room       = room_w'(fifo_depth) - count;

   assign do_push = push_valid & push_ready;
   assign do_pop  = pop_valid & pop_ready;

   always_ff @(posedge CLK) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;   // both or neither
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (do_push) begin
         buf_q[wr_ptr] <= push_data;
      end
   end

endmodule

// ==== source/adma_engine.sv ====
/*
 * ADMA2-style descriptor walker, memory to card direction only
 * upper bits of the 32-bit address word are ignored
 * reads issue only while the FIFO has room for everything in flight
 */
module adma_engine (
   input  logic                          CLK,
   input  logic                          reset,
   input  logic                          start,
   input  logic [sd_dma_pkg::addr_w-1:0] desc_base,
   mem_bus_if.controller                 bus,
   output logic [sd_dma_pkg::data_w-1:0] push_data,
   output logic                          push_valid,
   input  logic                          push_ready,
   input  logic [sd_dma_pkg::room_w-1:0] fifo_room,
   output logic                          busy,
   output logic                          done,
   output logic                          err
);
   import sd_dma_pkg::*;

   adma_state_t       state;
   logic [addr_w-1:0] desc_addr;     // descriptor being walked
   logic [addr_w-1:0] rd_addr;       // next data word
   logic [addr_w-1:0] tgt_addr;      // word 1 of descriptor
   logic [len_w-1:0]  words_left;    // reads still to issue
   logic              valid_q;
   logic              end_q;
   adma_act_t         act_q;
   logic [step_w-1:0] step_cnt;      // descriptors decoded this run
   logic              phase;         // fetch_addr, 0 issue and 1 capture
   logic              pend;          // read in flight, data lands on rdata
   logic              room_ok;
   logic              issue;
   logic              xfer_end;

   ////////////////////////////////////////////////////////////////////////////
   // read issue and push
   ////////////////////////////////////////////////////////////////////////////
   assign room_ok  = fifo_room > room_w'(pend);     // pending word needs a slot too
   assign issue    = (state == st_read_data) && (words_left != '0) && room_ok;
   assign xfer_end = (state == st_read_data) && (words_left == '0) && !pend;

   assign push_valid = pend;
   assign push_data  = bus.rdata;                  // held until next read

   assign busy = (state != st_idle) && (state != st_done) && (state != st_error);
   assign done = (state == st_done);
   assign err  = (state == st_error);

   always_comb begin
      bus.rd   = 1'b0;
      bus.addr = rd_addr;
      case (state)
         st_fetch_attr: begin
            bus.rd   = 1'b1;
            bus.addr = desc_addr;
         end
         st_fetch_addr: begin
            bus.rd   = ~phase;
            bus.addr = desc_addr + addr_w'(word_bytes);   // word 1
         end
         st_read_data: bus.rd = issue;
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // control FSM
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (reset) begin
         state      <= st_idle;
         phase      <= 1'b0;
         pend       <= 1'b0;
         step_cnt   <= '0;
         words_left <= '0;
      end else begin
         pend <= issue | (pend & ~push_ready);
         if (issue) begin
            words_left <= words_left - 1'b1;
         end
         case (state)
            st_idle: if (start) begin
               step_cnt <= '0;
               state    <= (desc_base[1:0] != 2'b00) ? st_error : st_fetch_attr;
            end
            st_fetch_attr: state <= st_fetch_addr;
            st_fetch_addr: begin
               phase <= ~phase;
               if (!phase) begin
                  words_left <= bus.rdata[len_msb:len_lsb];   // word 0 on rdata now
               end else begin
                  state <= st_decode;
               end
            end
            st_decode: begin
               // 17th descriptor in one run means a link loop
               if (!valid_q || step_cnt == step_w'(max_steps)) begin
                  state <= st_error;
               end else begin
                  step_cnt <= step_cnt + 1'b1;
                  case (act_q)
                     act_tran: state <= (tgt_addr[1:0] != 2'b00) ? st_error : st_read_data;
                     act_link: begin
                        if (tgt_addr[1:0] != 2'b00) begin
                           state <= st_error;
                        end else begin
                           state <= end_q ? st_done : st_fetch_attr;
                        end
                     end
                     default: state <= end_q ? st_done : st_fetch_attr;   // nop, rsv
                  endcase
               end
            end
            st_read_data: begin
               if (xfer_end) begin
                  state <= end_q ? st_done : st_fetch_attr;
               end else if (!issue && words_left != '0) begin
                  state <= st_wait_fifo;   // card side stalled
               end
            end
            st_wait_fifo: if (room_ok) state <= st_read_data;
            default: state <= st_idle;     // done and error are single pulses
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // address and descriptor registers
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (state == st_idle && start) begin
         desc_addr <= desc_base;
      end
      if (state == st_fetch_addr) begin
         if (!phase) begin
            valid_q <= bus.rdata[attr_valid];
            end_q   <= bus.rdata[attr_end];
            act_q   <= adma_act_t'(bus.rdata[act_msb:act_lsb]);
         end else begin
            tgt_addr <= bus.rdata[addr_w-1:0];
         end
      end
      if (state == st_decode) begin
         case (act_q)
            act_tran: rd_addr <= tgt_addr;
            act_link: desc_addr <= tgt_addr;
            default:  desc_addr <= desc_addr + addr_w'(desc_bytes);
         endcase
      end
      if (issue) begin
         rd_addr <= rd_addr + addr_w'(word_bytes);
      end
      if (xfer_end) begin
         desc_addr <= desc_addr + addr_w'(desc_bytes);   // next in table
      end
   end

endmodule

// ==== source/system_ram.sv ====
/*
 * word memory, DMA read port plus host write port
 * unaligned reads and writes are dropped, host writes only while not busy
 */
module system_ram (
   input  logic                          CLK,
   input  logic [sd_dma_pkg::addr_w-1:0] host_addr,
   input  logic [sd_dma_pkg::data_w-1:0] host_wdata,
   input  logic                          host_we,
   input  logic                          busy,
   mem_bus_if.memory                     bus
);
   import sd_dma_pkg::*;

   logic [data_w-1:0] mem [ram_words];

   logic [addr_w-3:0] rd_idx;      // word index from byte address
   logic [addr_w-3:0] wr_idx;
   logic              rd_ok;
   logic              wr_ok;

   assign rd_idx = bus.addr[addr_w-1:2];
   assign wr_idx = host_addr[addr_w-1:2];

   // aligned only, as the bus never splits a word
   assign rd_ok = bus.rd & (bus.addr[1:0] == 2'b00);
   assign wr_ok = host_we & ~busy & (host_addr[1:0] == 2'b00);   // locked during a run

   // host preload port
   always_ff @(posedge CLK) begin
      if (wr_ok) begin
         mem[wr_idx] <= host_wdata;
      end
   end

   // one cycle read, rdata holds when no read
   always_ff @(posedge CLK) begin
      if (rd_ok) begin
         bus.rdata <= mem[rd_idx];
      end
   end

endmodule

// ==== source/mem_bus_if.sv ====
/*
 * engine to memory read port
 * rdata valid one clock after rd, held until the next read
 */
interface mem_bus_if;
   import sd_dma_pkg::*;

   logic [addr_w-1:0] addr;    // byte address, low bits must be zero
   logic              rd;      // read strobe
   logic [data_w-1:0] rdata;   // registered read data

   modport controller (
      output addr,
      output rd,
      input  rdata
   );

   modport memory (
      input  addr,
      input  rd,
      output rdata
   );

endinterface

// ==== source/sd_dma_pkg.sv ====
/*
 * shared sizes, descriptor layout and enums for the ADMA2-style DMA path
 * addresses are 10-bit byte addresses, memory is word aligned only
 */
package sd_dma_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // memory and FIFO sizes
   ////////////////////////////////////////////////////////////////////////////
   localparam int ram_words  = 256;                  // 32-bit words
   localparam int addr_w     = 10;                   // byte address
   localparam int data_w     = 32;
   localparam int word_bytes = 4;
   localparam int fifo_depth = 8;                    // power of two
   localparam int fifo_ptr_w = $clog2(fifo_depth);
   localparam int room_w     = fifo_ptr_w + 1;       // 0..fifo_depth

   ////////////////////////////////////////////////////////////////////////////
   // descriptor layout
   ////////////////////////////////////////////////////////////////////////////
   localparam int desc_words = 2;                    // attr/len word, address word
   localparam int desc_bytes = desc_words * word_bytes;

   // word 0 fields
   localparam int attr_valid = 0;
   localparam int attr_end   = 1;
   localparam int act_lsb    = 4;
   localparam int act_msb    = 5;
   localparam int len_lsb    = 16;                   // length in words
   localparam int len_msb    = 31;
   localparam int len_w      = len_msb - len_lsb + 1;

   // loop guard, descriptors visited per run
   localparam int max_steps  = 16;
   localparam int step_w     = $clog2(max_steps + 1);

   typedef enum logic [1:0] {
      act_nop  = 2'b00,   // skip
      act_tran = 2'b01,   // read len words from address
      act_rsv  = 2'b10,   // treated like nop
      act_link = 2'b11    // word 1 points at next descriptor
   } adma_act_t;

   typedef enum logic [2:0] {
      st_idle,
      st_fetch_attr,
      st_fetch_addr,
      st_decode,
      st_read_data,
      st_wait_fifo,
      st_done,
      st_error
   } adma_state_t;

endpackage
